/* te_pkt.f */
+incdir+.
te_pkt_pkg.sv
te_pkt_fifo.sv
te_pkt_rx_parser.sv
te_pkt_bm_writer.sv
te_pkt.sv
te_pkt_tb_clk.sv
te_pkt_tb.sv

/* te_pkt.sv */
`timescale 1ns/1ps
`default_nettype none

`include "te_pkt_consts.svh"

module te_pkt
    import te_pkt_pkg::*;
(
    input  wire logic                                        clk_bus,
    input  wire logic                                        rst_n,
    // Inbound packet stream with one byte per cycle
    input  wire logic                                        pkt_sop,
    input  wire logic [`TE_PKT_BYTE_W-1:0]                   pkt_data,
    // Destination base as a buffer-memory word address
    input  wire logic [`TE_PKT_ADDR_W-1:0]                   ib_base,
    // Buffer-memory write port
    input  wire logic                                        bm_gnt,
    output logic                                             bm_req,
    output logic [`TE_PKT_ADDR_W-1:0]                        bm_addr,
    output logic [`TE_PKT_WORD_BYTES-1:0]                    bm_wstrb,
    output logic [`TE_PKT_WORD_BYTES*`TE_PKT_BYTE_W-1:0]     bm_wdata,
    // Read-request queue head
    input  wire logic                                        rdreq_pop,
    output logic                                             rdreq_valid,
    output rdreq_t                                           rdreq
);

    logic     word_push;
    bm_word_t parsed_word;
    logic     word_pop;
    bm_word_t head_word;
    logic     word_empty;
    logic     rdreq_push;
    rdreq_t   parsed_rdreq;
    logic     rdreq_empty;
    logic     rdreq_fifo_pop;

    // Queue head is valid whenever something is stored
    assign rdreq_valid    = !rdreq_empty;
    assign rdreq_fifo_pop = rdreq_pop && rdreq_valid;

    te_pkt_rx_parser rx_parser_i (
        .clk_bus    (clk_bus),
        .rst_n      (rst_n),
        .pkt_sop    (pkt_sop),
        .pkt_data   (pkt_data),
        .word_push  (word_push),
        .word       (parsed_word),
        .rdreq_push (rdreq_push),
        .rdreq_rec  (parsed_rdreq)
    );

    // Words wait here while the memory withholds its grant
    te_pkt_fifo #(
        .payload_t (bm_word_t),
        .DEPTH     (`TE_PKT_WORD_FIFO_DEPTH)
    ) word_fifo_i (
        .clk_bus (clk_bus),
        .rst_n   (rst_n),
        .push    (word_push),
        .pop     (word_pop),
        .wr_data (parsed_word),
        .rd_data (head_word),
        .empty   (word_empty),
        .full    ()
    );

    te_pkt_fifo #(
        .payload_t (rdreq_t),
        .DEPTH     (`TE_PKT_RDREQ_FIFO_DEPTH)
    ) rdreq_fifo_i (
        .clk_bus (clk_bus),
        .rst_n   (rst_n),
        .push    (rdreq_push),
        .pop     (rdreq_fifo_pop),
        .wr_data (parsed_rdreq),
        .rd_data (rdreq),
        .empty   (rdreq_empty),
        .full    ()
    );

    te_pkt_bm_writer bm_writer_i (
        .clk_bus    (clk_bus),
        .rst_n      (rst_n),
        .word_empty (word_empty),
        .word       (head_word),
        .ib_base    (ib_base),
        .bm_gnt     (bm_gnt),
        .word_pop   (word_pop),
        .bm_req     (bm_req),
        .bm_addr    (bm_addr),
        .bm_wstrb   (bm_wstrb),
        .bm_wdata   (bm_wdata)
    );

endmodule

`default_nettype wire

/* te_pkt_bm_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "te_pkt_consts.svh"

module te_pkt_bm_writer
    import te_pkt_pkg::*;
(
    input  wire logic                                        clk_bus,
    input  wire logic                                        rst_n,
    input  wire logic                                        word_empty,
    input  wire bm_word_t                                    word,
    input  wire logic [`TE_PKT_ADDR_W-1:0]                   ib_base,
    input  wire logic                                        bm_gnt,
    output logic                                             word_pop,
    output logic                                             bm_req,
    output logic [`TE_PKT_ADDR_W-1:0]                        bm_addr,
    output logic [`TE_PKT_WORD_BYTES-1:0]                    bm_wstrb,
    output logic [`TE_PKT_WORD_BYTES*`TE_PKT_BYTE_W-1:0]     bm_wdata
);

    localparam int ADDR_W = `TE_PKT_ADDR_W;

    // Idle waits for a record, request waits for the grant
    typedef enum logic {
        WR_IDLE,
        WR_REQ
    } wr_state_e;

    wr_state_e state;

    // Take the head record only while no request is open
    assign word_pop = (state == WR_IDLE) && !word_empty;
    assign bm_req   = (state == WR_REQ);

    always_ff @(posedge clk_bus) begin
        if (!rst_n) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (word_pop) state <= WR_REQ;
                // Grant edge ends the write and one idle cycle follows
                WR_REQ:  if (bm_gnt) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Request fields are loaded once per record
    always_ff @(posedge clk_bus) begin
        if (word_pop) begin
            // Destination base plus word index wraps at the top
            bm_addr  <= ib_base + ADDR_W'(word.waddr);
            bm_wstrb <= word.wstrb;
            bm_wdata <= word.wdata;
        end
    end

    // Fields hold until the memory takes them
    a_req_stable: assert property (@(posedge clk_bus) disable iff (!rst_n)
        (bm_req && !bm_gnt) |=> (bm_req && $stable(bm_addr)
                                 && $stable(bm_wstrb) && $stable(bm_wdata)))
        else $error("te_pkt_bm_writer request changed before grant");

endmodule

`default_nettype wire

/* te_pkt_consts.svh */
`ifndef TE_PKT_CONSTS_SVH
`define TE_PKT_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Data path widths
////////////////////////////////////////////////////////////////////////////

// Bits per byte on the packet stream and in buffer memory
`define TE_PKT_BYTE_W 8

// Bytes per buffer-memory word, and lane index width to match
`define TE_PKT_WORD_BYTES 8
`define TE_PKT_LANE_W 3

// Header byte address width, also the buffer-memory word address width
`define TE_PKT_ADDR_W 10

// Length field holds payload length minus one
`define TE_PKT_LEN_W 4

////////////////////////////////////////////////////////////////////////////
// Header field widths
////////////////////////////////////////////////////////////////////////////

`define TE_PKT_SDID_W 4
`define TE_PKT_XID_W 3
`define TE_PKT_TYPE_W 3

////////////////////////////////////////////////////////////////////////////
// Queue depths
////////////////////////////////////////////////////////////////////////////

`define TE_PKT_WORD_FIFO_DEPTH 8
`define TE_PKT_RDREQ_FIFO_DEPTH 2

`endif

/* te_pkt_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module te_pkt_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk_bus,
    input  wire logic     rst_n,
    input  wire logic     push,
    input  wire logic     pop,
    input  wire payload_t wr_data,
    output payload_t      rd_data,
    output logic          empty,
    output logic          full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Register array with the head entry always visible on rd_data
    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign rd_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk_bus) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk_bus) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks on the producer and consumer
    ////////////////////////////////////////////////////////////////////////////

    // Producer has no back-pressure, so it must never find the queue full
    a_push_not_full: assert property (@(posedge clk_bus) disable iff (!rst_n)
        push |-> !full)
        else $error("te_pkt_fifo push while full");

    // Consumer pops only what it has seen at the head
    a_pop_not_empty: assert property (@(posedge clk_bus) disable iff (!rst_n)
        pop |-> !empty)
        else $error("te_pkt_fifo pop while empty");

endmodule

`default_nettype wire

/* te_pkt_pkg.sv */
`default_nettype none

`include "te_pkt_consts.svh"

package te_pkt_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Packet type field in bits 7..5 of header byte 0
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [`TE_PKT_TYPE_W-1:0] {
        AK = 3'd0,
        WQ = 3'd1,
        WR = 3'd2,
        RQ = 3'd3,
        RR = 3'd4
    } pkt_type_e;

    ////////////////////////////////////////////////////////////////////////////
    // Records carried between parser, queues and writer
    ////////////////////////////////////////////////////////////////////////////

    // One buffer-memory write
    typedef struct packed {
        // Word index is the byte address without the lane bits
        logic [`TE_PKT_ADDR_W-`TE_PKT_LANE_W-1:0]       waddr;
        // One strobe per byte lane
        logic [`TE_PKT_WORD_BYTES-1:0]                   wstrb;
        // Lane 0 sits in the low byte
        logic [`TE_PKT_WORD_BYTES*`TE_PKT_BYTE_W-1:0]    wdata;
    } bm_word_t;

    // One read request as decoded from an RQ header
    typedef struct packed {
        logic [`TE_PKT_SDID_W-1:0] sid;
        logic [`TE_PKT_XID_W-1:0]  xid;
        // Byte address from header bytes 2 and 3
        logic [`TE_PKT_ADDR_W-1:0] addr;
        // Length minus one as in the header
        logic [`TE_PKT_LEN_W-1:0]  len;
    } rdreq_t;

endpackage

`default_nettype wire

/* te_pkt_rx_parser.sv */
`timescale 1ns/1ps
`default_nettype none

`include "te_pkt_consts.svh"

module te_pkt_rx_parser
    import te_pkt_pkg::*;
(
    input  wire logic                      clk_bus,
    input  wire logic                      rst_n,
    input  wire logic                      pkt_sop,
    input  wire logic [`TE_PKT_BYTE_W-1:0] pkt_data,
    output logic                           word_push,
    output bm_word_t                       word,
    output logic                           rdreq_push,
    output rdreq_t                         rdreq_rec
);

    localparam int BYTE_W    = `TE_PKT_BYTE_W;
    localparam int LANES     = `TE_PKT_WORD_BYTES;
    localparam int LANE_W    = `TE_PKT_LANE_W;
    localparam int ADDR_W    = `TE_PKT_ADDR_W;
    localparam int LEN_W     = `TE_PKT_LEN_W;
    // Byte 2 carries the top address bits, byte 3 the rest
    localparam int ADDR_HI_W = 4;
    localparam int ADDR_LO_W = ADDR_W - ADDR_HI_W;

    // Position within the packet
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HDR1,
        ST_HDR2,
        ST_HDR3,
        ST_DATA
    } rx_state_e;

    rx_state_e                   state;

    // Latched header fields
    pkt_type_e                   pkt_type;
    logic [`TE_PKT_XID_W-1:0]    xid;
    logic [`TE_PKT_SDID_W-1:0]   sid;
    logic [LEN_W-1:0]            len;
    logic [ADDR_HI_W-1:0]        addr_hi;

    // Payload walk
    logic [ADDR_W-1:0]           byte_addr;
    logic [LEN_W-1:0]            byte_cnt;

    // Word under assembly
    logic [ADDR_W-LANE_W-1:0]    acc_waddr;
    logic [LANES-1:0]            acc_strb;
    logic [LANES*BYTE_W-1:0]     acc_data;

    // Current byte merged into the word
    logic [LANE_W-1:0]           lane;
    logic [LANES-1:0]            merged_strb;
    logic [LANES*BYTE_W-1:0]     merged_data;
    logic                        last_byte;
    logic                        lane_full;
    logic                        data_byte;
    logic                        emit;

    ////////////////////////////////////////////////////////////////////////////
    // Byte placement
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        lane        = byte_addr[LANE_W-1:0];
        merged_strb = acc_strb;
        merged_data = acc_data;
        merged_strb[lane] = 1'b1;
        merged_data[lane*BYTE_W +: BYTE_W] = pkt_data;
    end

    assign last_byte = (byte_cnt == len);
    assign lane_full = (lane == {LANE_W{1'b1}});
    // A start of packet overrides any payload byte
    assign data_byte = (state == ST_DATA) && !pkt_sop;
    assign emit      = data_byte && (lane_full || last_byte);

    ////////////////////////////////////////////////////////////////////////////
    // Control state and push strobes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_bus) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            word_push  <= 1'b0;
            rdreq_push <= 1'b0;
            acc_strb   <= '0;
        end else begin
            word_push  <= 1'b0;
            rdreq_push <= 1'b0;
            if (pkt_sop) begin
                // Only WQ and RQ headers are followed
                if (pkt_data[7:5] == WQ || pkt_data[7:5] == RQ) begin
                    state <= ST_HDR1;
                end else begin
                    state <= ST_IDLE;
                end
                // Flush a word cut short by the new packet
                if (|acc_strb) begin
                    word_push <= 1'b1;
                    acc_strb  <= '0;
                end
            end else begin
                case (state)
                    ST_HDR1: state <= ST_HDR2;
                    ST_HDR2: state <= ST_HDR3;
                    ST_HDR3: begin
                        if (pkt_type == RQ) begin
                            rdreq_push <= 1'b1;
                            state      <= ST_IDLE;
                        end else begin
                            state <= ST_DATA;
                        end
                    end
                    ST_DATA: begin
                        if (emit) begin
                            word_push <= 1'b1;
                            acc_strb  <= '0;
                        end else begin
                            acc_strb <= merged_strb;
                        end
                        if (last_byte) begin
                            state <= ST_IDLE;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Header fields, payload and output records
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_bus) begin
        if (pkt_sop) begin
            pkt_type   <= pkt_type_e'(pkt_data[7:5]);
            xid        <= pkt_data[`TE_PKT_XID_W-1:0];
            // Partial word goes out as it stands
            word.waddr <= acc_waddr;
            word.wstrb <= acc_strb;
            word.wdata <= acc_data;
            acc_data   <= '0;
        end else begin
            case (state)
                ST_HDR1: sid <= pkt_data[7:4];
                ST_HDR2: begin
                    len     <= pkt_data[7:4];
                    addr_hi <= pkt_data[ADDR_HI_W-1:0];
                end
                ST_HDR3: begin
                    byte_addr      <= {addr_hi, pkt_data[ADDR_LO_W-1:0]};
                    byte_cnt       <= '0;
                    rdreq_rec.sid  <= sid;
                    rdreq_rec.xid  <= xid;
                    rdreq_rec.addr <= {addr_hi, pkt_data[ADDR_LO_W-1:0]};
                    rdreq_rec.len  <= len;
                end
                ST_DATA: begin
                    // Address wraps at the top of the byte space
                    byte_addr <= byte_addr + 1'b1;
                    byte_cnt  <= byte_cnt + 1'b1;
                    acc_waddr <= byte_addr[ADDR_W-1:LANE_W];
                    if (emit) begin
                        word.waddr <= byte_addr[ADDR_W-1:LANE_W];
                        word.wstrb <= merged_strb;
                        word.wdata <= merged_data;
                        acc_data   <= '0;
                    end else begin
                        acc_data <= merged_data;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* te_pkt_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "te_pkt_consts.svh"

module te_pkt_tb
    import te_pkt_pkg::*;
();

    localparam int ADDR_W     = `TE_PKT_ADDR_W;
    localparam int WORD_W     = `TE_PKT_WORD_BYTES * `TE_PKT_BYTE_W;
    localparam int N_RANDOM   = 150;
    // Up to three words per packet plus one held by the writer
    localparam int WORD_ROOM  = `TE_PKT_WORD_FIFO_DEPTH - 4;
    localparam int RDREQ_ROOM = `TE_PKT_RDREQ_FIFO_DEPTH - 1;

    // One packet to send
    typedef struct packed {
        logic [`TE_PKT_TYPE_W-1:0] ptype;
        logic [`TE_PKT_XID_W-1:0]  xid;
        logic [`TE_PKT_SDID_W-1:0] sid;
        logic [`TE_PKT_LEN_W-1:0]  len;
        logic [ADDR_W-1:0]         addr;
        logic [2:0]                extra;
        logic [2:0]                gap;
    } pkt_desc_t;

    logic                            clk_bus;
    logic                            rst_n;
    logic                            pkt_sop;
    logic [`TE_PKT_BYTE_W-1:0]       pkt_data;
    logic [ADDR_W-1:0]               ib_base;
    logic                            bm_gnt;
    logic                            bm_req;
    logic [ADDR_W-1:0]               bm_addr;
    logic [`TE_PKT_WORD_BYTES-1:0]   bm_wstrb;
    logic [WORD_W-1:0]               bm_wdata;
    logic                            rdreq_pop;
    logic                            rdreq_valid;
    rdreq_t                          rdreq;

    // Model queues with the oldest entry first
    pkt_desc_t pkts [$];
    bm_word_t  exp_writes [$];
    rdreq_t    exp_rdreqs [$];

    int   n_exp_writes = 0;
    int   n_exp_rdreqs = 0;
    int   writes_seen  = 0;
    int   rdreqs_seen  = 0;
    int   errors       = 0;
    int   final_errors = 0;
    int   cycle        = 0;
    int   cycle_limit  = 0;
    logic started      = 1'b0;

    // Last request still waiting for its grant
    logic                          prev_wait;
    logic [ADDR_W-1:0]             prev_addr;
    logic [`TE_PKT_WORD_BYTES-1:0] prev_strb;
    logic [WORD_W-1:0]             prev_data;

    te_pkt_tb_clk clk_gen_i (
        .clk_bus (clk_bus),
        .rst_n   (rst_n)
    );

    te_pkt te_pkt_i (
        .clk_bus     (clk_bus),
        .rst_n       (rst_n),
        .pkt_sop     (pkt_sop),
        .pkt_data    (pkt_data),
        .ib_base     (ib_base),
        .bm_gnt      (bm_gnt),
        .bm_req      (bm_req),
        .bm_addr     (bm_addr),
        .bm_wstrb    (bm_wstrb),
        .bm_wdata    (bm_wdata),
        .rdreq_pop   (rdreq_pop),
        .rdreq_valid (rdreq_valid),
        .rdreq       (rdreq)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // One stream byte, then wait for the next edge plus 1 ns
    task automatic drive_byte(input logic sop, input logic [7:0] data);
        pkt_sop  = sop;
        pkt_data = data;
        @(posedge clk_bus);
        #1;
    endtask

    // Build the expected records, then put the packet on the stream
    task automatic send_packet(input pkt_desc_t d);
        logic [7:0]        hdr [4];
        logic [7:0]        body [16];
        logic [ADDR_W-1:0] a;
        bm_word_t          w;
        rdreq_t            r;
        int                n_body;
        int                k;
        // Hold off until the queues have room for what this packet adds
        while (d.ptype == WQ && exp_writes.size() > WORD_ROOM) begin
            drive_byte(1'b0, 8'($urandom));
        end
        while (d.ptype == RQ && exp_rdreqs.size() > RDREQ_ROOM) begin
            drive_byte(1'b0, 8'($urandom));
        end
        // Header with random unused fields
        hdr[0] = {d.ptype, 2'($urandom), d.xid};
        hdr[1] = {d.sid, 4'($urandom)};
        hdr[2] = {d.len, d.addr[9:6]};
        hdr[3] = {2'($urandom), d.addr[5:0]};
        for (k = 0; k < 16; k++) begin
            body[k] = 8'($urandom);
        end
        n_body = (d.ptype == WQ) ? int'(d.len) + 1 : int'(d.extra);
        if (d.ptype == WQ) begin
            // Payload byte k lands at addr + k
            // A word closes on lane 7 or on the last byte
            w = '0;
            for (k = 0; k <= int'(d.len); k++) begin
                a = d.addr + ADDR_W'(k);
                w.waddr = a[ADDR_W-1:3];
                w.wstrb[a[2:0]] = 1'b1;
                w.wdata[a[2:0]*8 +: 8] = body[k];
                if (a[2:0] == 3'd7 || k == int'(d.len)) begin
                    exp_writes.push_back(w);
                    n_exp_writes++;
                    w = '0;
                end
            end
        end else if (d.ptype == RQ) begin
            r.sid  = d.sid;
            r.xid  = d.xid;
            r.addr = d.addr;
            r.len  = d.len;
            exp_rdreqs.push_back(r);
            n_exp_rdreqs++;
        end
        drive_byte(1'b1, hdr[0]);
        for (k = 1; k < 4; k++) begin
            drive_byte(1'b0, hdr[k]);
        end
        for (k = 0; k < n_body; k++) begin
            drive_byte(1'b0, body[k]);
        end
        for (k = 0; k < int'(d.gap); k++) begin
            drive_byte(1'b0, 8'($urandom));
        end
    endtask

    initial begin
        pkt_desc_t d;
        int        i;
        int        total_bytes;
        void'($urandom(32'h8a10));
        pkt_sop   = 1'b0;
        pkt_data  = '0;
        bm_gnt    = 1'b0;
        rdreq_pop = 1'b0;
        ib_base   = ADDR_W'($urandom);

        // Aligned full word first, then a write across the top of the address space
        d       = '0;
        d.ptype = WQ;
        d.len   = 4'd7;
        d.addr  = {7'($urandom), 3'b000};
        d.gap   = 3'd2;
        pkts.push_back(d);
        d.len   = 4'd15;
        d.addr  = 10'd1021;
        pkts.push_back(d);
        for (i = 0; i < N_RANDOM; i++) begin
            d.ptype = 3'($urandom_range(4, 0));
            d.xid   = 3'($urandom);
            d.sid   = 4'($urandom);
            d.len   = 4'($urandom);
            d.addr  = 10'($urandom);
            d.extra = 3'($urandom);
            d.gap   = 3'($urandom);
            pkts.push_back(d);
        end

        // Run limit from the stream length
        total_bytes = 0;
        foreach (pkts[i]) begin
            total_bytes += 4 + int'(pkts[i].gap);
            total_bytes += (pkts[i].ptype == WQ) ? int'(pkts[i].len) + 1 : int'(pkts[i].extra);
        end
        cycle_limit = 4 * total_bytes + 2000;

        // Grant and pop responders draw new random levels every cycle
        fork
            forever begin
                @(posedge clk_bus);
                #1;
                bm_gnt    = 1'($urandom);
                rdreq_pop = ($urandom_range(3, 0) == 0);
            end
        join_none

        wait (rst_n === 1'b1);
        @(posedge clk_bus);
        #1;
        for (i = 0; i < 3; i++) begin
            drive_byte(1'b0, 8'($urandom));
        end
        started = 1'b1;
        foreach (pkts[i]) begin
            send_packet(pkts[i]);
        end

        // Drain, then look for stray outputs
        while (exp_writes.size() > 0 || exp_rdreqs.size() > 0) begin
            drive_byte(1'b0, 8'($urandom));
        end
        for (i = 0; i < 10; i++) begin
            drive_byte(1'b0, 8'($urandom));
        end

        assert (writes_seen == n_exp_writes) else begin
            final_errors++;
            $display("Mismatch write count: got %h expected %h", writes_seen, n_exp_writes);
        end
        assert (rdreqs_seen == n_exp_rdreqs) else begin
            final_errors++;
            $display("Mismatch read request count: got %h expected %h",
                     rdreqs_seen, n_exp_rdreqs);
        end

        $display("Writes checked %0d, read requests checked %0d, errors %0d",
                 writes_seen, rdreqs_seen, errors + final_errors);
        if (errors + final_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output checks sampled on the edge the DUT uses
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_bus) begin
        bm_word_t          exp_w;
        rdreq_t            exp_r;
        logic [ADDR_W-1:0] exp_addr;
        logic [WORD_W-1:0] mask;
        int                i;
        if (!rst_n) begin
            prev_wait = 1'b0;
        end else begin
            // Quiet outputs until the first packet
            if (!started) begin
                assert (!bm_req && !rdreq_valid) else begin
                    errors++;
                    $display("Output active before the first packet after reset");
                end
            end

            // A waiting request keeps every field
            if (prev_wait) begin
                assert (bm_req) else begin
                    errors++;
                    $display("bm_req dropped before a grant");
                end
                assert (bm_addr == prev_addr) else begin
                    errors++;
                    $display("Mismatch bm_addr: got %h expected %h", bm_addr, prev_addr);
                end
                assert (bm_wstrb == prev_strb) else begin
                    errors++;
                    $display("Mismatch bm_wstrb: got %h expected %h", bm_wstrb, prev_strb);
                end
                assert (bm_wdata == prev_data) else begin
                    errors++;
                    $display("Mismatch bm_wdata: got %h expected %h", bm_wdata, prev_data);
                end
            end

            // Grant edge completes a write
            if (bm_req && bm_gnt) begin
                assert (exp_writes.size() > 0) else begin
                    errors++;
                    $display("Buffer write granted while no write was expected");
                end
                if (exp_writes.size() > 0) begin
                    exp_w    = exp_writes.pop_front();
                    exp_addr = ib_base + ADDR_W'(exp_w.waddr);
                    for (i = 0; i < `TE_PKT_WORD_BYTES; i++) begin
                        mask[i*8 +: 8] = {8{exp_w.wstrb[i]}};
                    end
                    assert (bm_addr == exp_addr) else begin
                        errors++;
                        $display("Mismatch bm_addr: got %h expected %h", bm_addr, exp_addr);
                    end
                    assert (bm_wstrb == exp_w.wstrb) else begin
                        errors++;
                        $display("Mismatch bm_wstrb: got %h expected %h",
                                 bm_wstrb, exp_w.wstrb);
                    end
                    // Only strobed lanes carry data
                    assert ((bm_wdata & mask) == exp_w.wdata) else begin
                        errors++;
                        $display("Mismatch bm_wdata: got %h expected %h",
                                 bm_wdata & mask, exp_w.wdata);
                    end
                end
                writes_seen++;
            end
            prev_wait = bm_req && !bm_gnt;
            prev_addr = bm_addr;
            prev_strb = bm_wstrb;
            prev_data = bm_wdata;

            // Queue head must match the oldest expected request until popped
            if (rdreq_valid) begin
                assert (exp_rdreqs.size() > 0) else begin
                    errors++;
                    $display("Read request valid while none was expected");
                end
                if (exp_rdreqs.size() > 0) begin
                    exp_r = exp_rdreqs[0];
                    assert (rdreq == exp_r) else begin
                        errors++;
                        $display("Mismatch rdreq: got %h expected %h", rdreq, exp_r);
                    end
                    if (rdreq_pop) begin
                        void'(exp_rdreqs.pop_front());
                    end
                end
                if (rdreq_pop) begin
                    rdreqs_seen++;
                end
            end
        end
    end

    // Cycle budget
    always @(posedge clk_bus) begin
        cycle = cycle + 1;
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d writes and %0d read requests pending",
                     cycle, exp_writes.size(), exp_rdreqs.size());
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* te_pkt_tb_clk.sv */
`timescale 1ns/1ps
`default_nettype none

module te_pkt_tb_clk (
    output logic clk_bus,
    output logic rst_n
);

    // 10 ns bus clock
    initial begin
        clk_bus = 1'b0;
        forever #5 clk_bus = ~clk_bus;
    end

    // Reset held for four rising edges and released just after the fourth
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk_bus);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
